//--- verilog/l1d_pkg.sv
/*
 l1d_pkg
 Geometry, field types, the MSHR target record and the controller state
 encoding shared by every block of the L1 data cache.
*/
package l1d_pkg;

  // 16-bit physical space, 16-byte lines of two 64-bit words
  localparam int PADDR_BITS    = 16;
  localparam int WORD_BITS     = 64;
  localparam int LINE_WORDS    = 2;
  localparam int OFFSET_BITS   = 4;
  localparam int LINE_BITS     = 128;

  // direct-mapped, eight sets
  localparam int SETS          = 8;
  localparam int INDEX_BITS    = 3;
  localparam int LINE_TAG_BITS = 9;

  localparam int MSHR_COUNT    = 4;
  localparam int MSHR_DEPTH    = 4;
  localparam int MSHR_IDX_BITS = 2;
  localparam int MSHR_PTR_BITS = 2;

  localparam int REQ_TAG_BITS  = 4;

  typedef logic [PADDR_BITS-1:0]             paddr_t;
  typedef logic [PADDR_BITS-OFFSET_BITS-1:0] line_addr_t;
  typedef logic [WORD_BITS-1:0]              word_t;
  typedef logic [LINE_BITS-1:0]              line_t;
  typedef logic [REQ_TAG_BITS-1:0]           req_tag_t;

  typedef enum logic {
    LOAD,
    STORE
  } req_kind_t;

  // one merged request waiting on an outstanding refill
  typedef struct packed {
    req_kind_t kind;
    logic      word_sel;
    word_t     data;
    req_tag_t  req_tag;
  } mshr_target_t;

  typedef enum logic [3:0] {
    IDLE,
    LOOKUP,
    MISS_ALLOC,
    SEND_REQ,
    RESPOND,
    EVICT,
    INSTALL,
    DRAIN_PICK,
    DRAIN_ACCESS,
    DRAIN_RESP
  } ctrl_state_t;

endpackage

//--- verilog/array_port_if.sv
`timescale 1ns/1ps
/*
 array_port_if
 Access port between the cache controller and the direct-mapped line store.
 Lookup results and victim information come back combinationally.
*/
interface array_port_if;

  logic [l1d_pkg::INDEX_BITS-1:0]    index;
  logic [l1d_pkg::LINE_TAG_BITS-1:0] line_tag;
  logic                              word_sel;
  logic                              we;
  l1d_pkg::word_t                    wdata;
  logic                              install;
  l1d_pkg::line_t                    install_line;

  logic                              hit;
  l1d_pkg::word_t                    rdata;
  logic                              victim_dirty;
  l1d_pkg::line_addr_t               victim_addr;
  l1d_pkg::line_t                    victim_line;

  modport ctrl (output index, line_tag, word_sel, we, wdata, install, install_line,
                input  hit, rdata, victim_dirty, victim_addr, victim_line);

  modport store (input  index, line_tag, word_sel, we, wdata, install, install_line,
                 output hit, rdata, victim_dirty, victim_addr, victim_line);

endinterface

//--- verilog/mshr_port_if.sv
`timescale 1ns/1ps
/*
 mshr_port_if
 Control and status port between the cache controller and the MSHR file.
*/
interface mshr_port_if;

  l1d_pkg::line_addr_t                lookup_addr;
  logic                               alloc;
  logic                               push;
  logic                               pop;
  logic [l1d_pkg::MSHR_IDX_BITS-1:0]  pop_idx;
  l1d_pkg::mshr_target_t              target;

  logic                               match;
  logic [l1d_pkg::MSHR_IDX_BITS-1:0]  match_idx;
  logic                               match_full;
  logic                               free_avail;
  // a free entry exists and no live entry has a full target queue
  logic                               can_accept;
  l1d_pkg::mshr_target_t              head_target;
  logic                               head_empty;

  modport ctrl (output lookup_addr, alloc, push, pop, pop_idx, target,
                input  match, match_idx, match_full, free_avail, can_accept,
                       head_target, head_empty);

  modport mshrs (input  lookup_addr, alloc, push, pop, pop_idx, target,
                 output match, match_idx, match_full, free_avail, can_accept,
                        head_target, head_empty);

endinterface

//--- verilog/l1d_line_store.sv
`timescale 1ns/1ps
/*
 l1d_line_store
 Direct-mapped tag, valid, dirty and data arrays. Word writes on store hits,
 whole-line installs on refills, combinational hit and victim outputs.
*/
module l1d_line_store (
  input logic         clk_in,
  input logic         rst_N_in,
  array_port_if.store port
);

  logic [l1d_pkg::SETS-1:0]          valid_q;
  logic [l1d_pkg::SETS-1:0]          dirty_q;
  logic [l1d_pkg::LINE_TAG_BITS-1:0] tag_q  [l1d_pkg::SETS];
  l1d_pkg::line_t                    line_q [l1d_pkg::SETS];

  logic [l1d_pkg::LINE_WORDS-1:0][l1d_pkg::WORD_BITS-1:0] cur_words;

  assign cur_words = line_q[port.index];

  assign port.hit          = valid_q[port.index] && (tag_q[port.index] == port.line_tag);
  assign port.rdata        = cur_words[port.word_sel];
  assign port.victim_dirty = valid_q[port.index] && dirty_q[port.index];
  assign port.victim_addr  = {tag_q[port.index], port.index};
  assign port.victim_line  = line_q[port.index];

  // state bits of each set
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (port.install) begin
      valid_q[port.index] <= 1'b1;
      dirty_q[port.index] <= 1'b0;
    end else if (port.we) begin
      dirty_q[port.index] <= 1'b1;
    end
  end

  // tag and data storage
  always_ff @(posedge clk_in) begin
    if (port.install) begin
      tag_q[port.index]  <= port.line_tag;
      line_q[port.index] <= port.install_line;
    end else if (port.we) begin
      line_q[port.index][port.word_sel*l1d_pkg::WORD_BITS +: l1d_pkg::WORD_BITS] <= port.wdata;
    end
  end

  // a refill install and a word write must never overlap on the array
  a_no_write_install: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    !(port.we && port.install));

endmodule

//--- verilog/l1d_mshr_file.sv
`timescale 1ns/1ps
/*
 l1d_mshr_file
 Miss status holding registers. Each entry keeps the missing line address and
 a circular queue of merged targets, drained in arrival order.
*/
module l1d_mshr_file (
  input logic          clk_in,
  input logic          rst_N_in,
  mshr_port_if.mshrs   port
);

  logic [l1d_pkg::MSHR_COUNT-1:0] valid_q;
  l1d_pkg::line_addr_t            addr_q  [l1d_pkg::MSHR_COUNT];
  l1d_pkg::mshr_target_t          fifo_q  [l1d_pkg::MSHR_COUNT][l1d_pkg::MSHR_DEPTH];
  logic [l1d_pkg::MSHR_PTR_BITS-1:0] head_q  [l1d_pkg::MSHR_COUNT];
  logic [l1d_pkg::MSHR_PTR_BITS-1:0] tail_q  [l1d_pkg::MSHR_COUNT];
  logic [l1d_pkg::MSHR_PTR_BITS:0]   count_q [l1d_pkg::MSHR_COUNT];

  logic [l1d_pkg::MSHR_IDX_BITS-1:0] free_idx;
  logic [l1d_pkg::MSHR_IDX_BITS-1:0] push_idx;
  logic                              any_full;

  always_comb begin
    port.match      = 1'b0;
    port.match_idx  = '0;
    port.free_avail = 1'b0;
    free_idx        = '0;
    any_full        = 1'b0;
    for (int i = 0; i < l1d_pkg::MSHR_COUNT; i++) begin
      if (valid_q[i] && addr_q[i] == port.lookup_addr) begin
        port.match     = 1'b1;
        port.match_idx = l1d_pkg::MSHR_IDX_BITS'(i);
      end
      // first hit in ascending order gives the lowest free entry
      if (!valid_q[i] && !port.free_avail) begin
        port.free_avail = 1'b1;
        free_idx        = l1d_pkg::MSHR_IDX_BITS'(i);
      end
      if (valid_q[i] && count_q[i] == l1d_pkg::MSHR_DEPTH) begin
        any_full = 1'b1;
      end
    end
  end

  assign port.match_full  = count_q[port.match_idx] == l1d_pkg::MSHR_DEPTH;
  assign port.can_accept  = port.free_avail && !any_full;
  assign port.head_target = fifo_q[port.pop_idx][head_q[port.pop_idx]];
  assign port.head_empty  = count_q[port.pop_idx] == '0;

  // a fresh allocation takes the first target, otherwise it merges into the match
  assign push_idx = port.alloc ? free_idx : port.match_idx;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < l1d_pkg::MSHR_COUNT; i++) begin
        head_q[i]  <= '0;
        tail_q[i]  <= '0;
        count_q[i] <= '0;
      end
    end else begin
      if (port.alloc) begin
        valid_q[free_idx] <= 1'b1;
      end
      if (port.push) begin
        tail_q[push_idx] <= tail_q[push_idx] + 1'b1;
      end
      if (port.pop) begin
        head_q[port.pop_idx] <= head_q[port.pop_idx] + 1'b1;
        // the entry is released once its last target leaves
        if (count_q[port.pop_idx] == 1) begin
          valid_q[port.pop_idx] <= 1'b0;
        end
      end
      for (int i = 0; i < l1d_pkg::MSHR_COUNT; i++) begin
        if ((port.push && push_idx == i) && !(port.pop && port.pop_idx == i)) begin
          count_q[i] <= count_q[i] + 1'b1;
        end else if (!(port.push && push_idx == i) && (port.pop && port.pop_idx == i)) begin
          count_q[i] <= count_q[i] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (port.alloc) begin
      addr_q[free_idx] <= port.lookup_addr;
    end
    if (port.push) begin
      fifo_q[push_idx][tail_q[push_idx]] <= port.target;
    end
  end

  a_no_push_full: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    port.push |-> count_q[push_idx] != l1d_pkg::MSHR_DEPTH);

  a_no_pop_empty: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    port.pop |-> count_q[port.pop_idx] != 0);

endmodule

//--- verilog/l1d_controller.sv
`timescale 1ns/1ps
/*
 l1d_controller
 Cache FSM. Takes LSU requests, resolves hits and misses, merges misses into
 MSHRs, writes back dirty victims on refill and drains merged targets in order.
*/
module l1d_controller (
  input  logic              clk_in,
  input  logic              rst_N_in,
  array_port_if.ctrl        arr,
  mshr_port_if.ctrl         mshr,
  input  logic              lsu_req_valid,
  output logic              lsu_req_ready,
  input  l1d_pkg::paddr_t   lsu_req_addr,
  input  logic              lsu_req_we,
  input  l1d_pkg::word_t    lsu_req_data,
  input  l1d_pkg::req_tag_t lsu_req_tag,
  output logic              lsu_resp_valid,
  input  logic              lsu_resp_ready,
  output l1d_pkg::word_t    lsu_resp_data,
  output l1d_pkg::req_tag_t lsu_resp_tag,
  output logic              lsu_resp_write,
  output logic              lc_req_valid,
  input  logic              lc_req_ready,
  output l1d_pkg::paddr_t   lc_req_addr,
  output logic              lc_req_we,
  output l1d_pkg::line_t    lc_req_line,
  input  logic              lc_resp_valid,
  output logic              lc_resp_ready,
  input  l1d_pkg::paddr_t   lc_resp_addr,
  input  l1d_pkg::line_t    lc_resp_line
);

  l1d_pkg::ctrl_state_t state_q, state_d;

  l1d_pkg::paddr_t   req_addr_q;
  logic              req_we_q;
  l1d_pkg::word_t    req_data_q;
  l1d_pkg::req_tag_t req_tag_q;

  // refill in progress and the target currently being replayed
  l1d_pkg::line_addr_t               refill_addr_q;
  l1d_pkg::line_t                    refill_line_q;
  logic [l1d_pkg::MSHR_IDX_BITS-1:0] drain_idx_q;
  l1d_pkg::mshr_target_t             tgt_q;

  l1d_pkg::word_t    resp_data_q;
  l1d_pkg::req_tag_t resp_tag_q;
  logic              resp_write_q;

  logic                refilling;
  logic                draining;
  l1d_pkg::line_addr_t cur_line;

  assign refilling = state_q inside {l1d_pkg::EVICT, l1d_pkg::INSTALL, l1d_pkg::DRAIN_PICK,
                                     l1d_pkg::DRAIN_ACCESS, l1d_pkg::DRAIN_RESP};
  assign draining  = state_q == l1d_pkg::DRAIN_ACCESS;
  assign cur_line  = refilling ? refill_addr_q
                               : req_addr_q[l1d_pkg::PADDR_BITS-1:l1d_pkg::OFFSET_BITS];

  assign arr.index        = cur_line[l1d_pkg::INDEX_BITS-1:0];
  assign arr.line_tag     = cur_line[l1d_pkg::INDEX_BITS +: l1d_pkg::LINE_TAG_BITS];
  assign arr.word_sel     = draining ? tgt_q.word_sel : req_addr_q[l1d_pkg::OFFSET_BITS-1];
  assign arr.wdata        = draining ? tgt_q.data : req_data_q;
  assign arr.install      = state_q == l1d_pkg::INSTALL;
  assign arr.install_line = refill_line_q;
  // a line with a live MSHR never takes a direct hit, it queues behind the refill
  assign arr.we = (state_q == l1d_pkg::LOOKUP && arr.hit && !mshr.match && req_we_q) ||
                  (draining && tgt_q.kind == l1d_pkg::STORE);

  assign mshr.lookup_addr = cur_line;
  assign mshr.alloc       = state_q == l1d_pkg::MISS_ALLOC && mshr.free_avail;
  assign mshr.push        = mshr.alloc ||
                            (state_q == l1d_pkg::LOOKUP && mshr.match && !mshr.match_full);
  assign mshr.pop         = state_q == l1d_pkg::DRAIN_PICK && !mshr.head_empty;
  assign mshr.pop_idx     = drain_idx_q;
  assign mshr.target      = '{kind:     req_we_q ? l1d_pkg::STORE : l1d_pkg::LOAD,
                              word_sel: req_addr_q[l1d_pkg::OFFSET_BITS-1],
                              data:     req_data_q,
                              req_tag:  req_tag_q};

  // refills win over new requests in IDLE
  assign lsu_req_ready  = state_q == l1d_pkg::IDLE && !lc_resp_valid && mshr.can_accept;
  assign lc_resp_ready  = state_q == l1d_pkg::IDLE;
  assign lsu_resp_valid = state_q inside {l1d_pkg::RESPOND, l1d_pkg::DRAIN_RESP};
  assign lsu_resp_data  = resp_data_q;
  assign lsu_resp_tag   = resp_tag_q;
  assign lsu_resp_write = resp_write_q;

  assign lc_req_valid = state_q == l1d_pkg::SEND_REQ ||
                        (state_q == l1d_pkg::EVICT && arr.victim_dirty);
  assign lc_req_we    = state_q == l1d_pkg::EVICT;
  assign lc_req_addr  = {(state_q == l1d_pkg::EVICT) ? arr.victim_addr : cur_line,
                         l1d_pkg::OFFSET_BITS'(0)};
  assign lc_req_line  = (state_q == l1d_pkg::EVICT) ? arr.victim_line : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      l1d_pkg::IDLE: begin
        if (lc_resp_valid) begin
          state_d = l1d_pkg::EVICT;
        end else if (lsu_req_valid && lsu_req_ready) begin
          state_d = l1d_pkg::LOOKUP;
        end
      end
      l1d_pkg::LOOKUP: begin
        if (mshr.match) begin
          if (!mshr.match_full) state_d = l1d_pkg::IDLE;
        end else begin
          state_d = arr.hit ? l1d_pkg::RESPOND : l1d_pkg::MISS_ALLOC;
        end
      end
      l1d_pkg::MISS_ALLOC: if (mshr.free_avail) state_d = l1d_pkg::SEND_REQ;
      l1d_pkg::SEND_REQ:   if (lc_req_ready) state_d = l1d_pkg::IDLE;
      l1d_pkg::RESPOND:    if (lsu_resp_ready) state_d = l1d_pkg::IDLE;
      l1d_pkg::EVICT:      if (!arr.victim_dirty || lc_req_ready) state_d = l1d_pkg::INSTALL;
      l1d_pkg::INSTALL:    state_d = l1d_pkg::DRAIN_PICK;
      l1d_pkg::DRAIN_PICK: state_d = mshr.head_empty ? l1d_pkg::IDLE : l1d_pkg::DRAIN_ACCESS;
      l1d_pkg::DRAIN_ACCESS: state_d = l1d_pkg::DRAIN_RESP;
      l1d_pkg::DRAIN_RESP: if (lsu_resp_ready) state_d = l1d_pkg::DRAIN_PICK;
      default:             state_d = l1d_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= l1d_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_in) begin
    if (lsu_req_valid && lsu_req_ready) begin
      req_addr_q <= lsu_req_addr;
      req_we_q   <= lsu_req_we;
      req_data_q <= lsu_req_data;
      req_tag_q  <= lsu_req_tag;
    end
    if (state_q == l1d_pkg::IDLE && lc_resp_valid) begin
      refill_addr_q <= lc_resp_addr[l1d_pkg::PADDR_BITS-1:l1d_pkg::OFFSET_BITS];
      refill_line_q <= lc_resp_line;
    end
    // the entry index is latched before the final pop frees it
    if (state_q == l1d_pkg::EVICT) begin
      drain_idx_q <= mshr.match_idx;
    end
    if (mshr.pop) begin
      tgt_q <= mshr.head_target;
    end
    if (state_q == l1d_pkg::LOOKUP) begin
      resp_data_q  <= req_we_q ? '0 : arr.rdata;
      resp_tag_q   <= req_tag_q;
      resp_write_q <= req_we_q;
    end else if (draining) begin
      resp_data_q  <= (tgt_q.kind == l1d_pkg::STORE) ? '0 : arr.rdata;
      resp_tag_q   <= tgt_q.req_tag;
      resp_write_q <= tgt_q.kind == l1d_pkg::STORE;
    end
  end

  a_lc_req_hold: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    lc_req_valid && !lc_req_ready |=> lc_req_valid && $stable(lc_req_addr));

endmodule

//--- verilog/l1d_top.sv
`timescale 1ns/1ps
/*
 l1d_top
 Non-blocking write-back L1 data cache. Connects the controller, line store
 and MSHR file between the LSU and the lower-level cache.
*/
module l1d_top (
  input  logic              clk_in,
  input  logic              rst_N_in,
  input  logic              lsu_req_valid,
  output logic              lsu_req_ready,
  input  l1d_pkg::paddr_t   lsu_req_addr,
  input  logic              lsu_req_we,
  input  l1d_pkg::word_t    lsu_req_data,
  input  l1d_pkg::req_tag_t lsu_req_tag,
  output logic              lsu_resp_valid,
  input  logic              lsu_resp_ready,
  output l1d_pkg::word_t    lsu_resp_data,
  output l1d_pkg::req_tag_t lsu_resp_tag,
  output logic              lsu_resp_write,
  output logic              lc_req_valid,
  input  logic              lc_req_ready,
  output l1d_pkg::paddr_t   lc_req_addr,
  output logic              lc_req_we,
  output l1d_pkg::line_t    lc_req_line,
  input  logic              lc_resp_valid,
  output logic              lc_resp_ready,
  input  l1d_pkg::paddr_t   lc_resp_addr,
  input  l1d_pkg::line_t    lc_resp_line
);

  array_port_if arr_if ();
  mshr_port_if  mshr_if ();

  l1d_controller u_ctrl (
    .clk_in         (clk_in),
    .rst_N_in       (rst_N_in),
    .arr            (arr_if.ctrl),
    .mshr           (mshr_if.ctrl),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req_addr   (lsu_req_addr),
    .lsu_req_we     (lsu_req_we),
    .lsu_req_data   (lsu_req_data),
    .lsu_req_tag    (lsu_req_tag),
    .lsu_resp_valid (lsu_resp_valid),
    .lsu_resp_ready (lsu_resp_ready),
    .lsu_resp_data  (lsu_resp_data),
    .lsu_resp_tag   (lsu_resp_tag),
    .lsu_resp_write (lsu_resp_write),
    .lc_req_valid   (lc_req_valid),
    .lc_req_ready   (lc_req_ready),
    .lc_req_addr    (lc_req_addr),
    .lc_req_we      (lc_req_we),
    .lc_req_line    (lc_req_line),
    .lc_resp_valid  (lc_resp_valid),
    .lc_resp_ready  (lc_resp_ready),
    .lc_resp_addr   (lc_resp_addr),
    .lc_resp_line   (lc_resp_line)
  );

  l1d_line_store u_store (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .port     (arr_if.store)
  );

  l1d_mshr_file u_mshrs (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .port     (mshr_if.mshrs)
  );

endmodule

//--- tests/tb_lc_model.svh
/*
 tb_lc_model
 Lower-level cache model. Keeps the golden memory, answers each line read with
 a refill after a random latency and checks every write-back against the
 expected line contents.
*/
  l1d_pkg::word_t  gold_mem [WIN_WORDS];
  l1d_pkg::paddr_t rd_line_q [$];
  int              rd_wait_q [$];
  logic            resp_taken;
  logic            hold_lc;
  l1d_pkg::paddr_t held_lc_addr;
  logic            held_lc_we;
  l1d_pkg::line_t  held_lc_line;
  int              lc_stretch;

  // an unwritten word holds its own word address, repeated four times
  function automatic l1d_pkg::word_t fill_word(input int widx);
    logic [15:0] waddr;
    waddr = 16'((WIN_BASE >> 3) + widx);
    return {4{waddr}};
  endfunction

  task automatic init_memory();
    for (int i = 0; i < WIN_WORDS; i++) begin
      gold_mem[i] = fill_word(i);
      exp_mem[i]  = fill_word(i);
    end
    resp_taken = 1'b0;
    hold_lc    = 1'b0;
    lc_stretch = 0;
  endtask

  task automatic lc_observe();
    int w;
    if (hold_lc) begin
      checks++;
      if (!lc_req_valid) begin
        protocol_failure("lc request dropped before it was taken");
      end
      if (lc_req_addr != held_lc_addr) begin
        value_mismatch("lc_req_addr", lc_req_addr, held_lc_addr);
      end
      if (lc_req_we != held_lc_we) begin
        value_mismatch("lc_req_we", lc_req_we, held_lc_we);
      end
      if (lc_req_line != held_lc_line) begin
        value_mismatch("lc_req_line", lc_req_line, held_lc_line);
      end
    end
    hold_lc      = lc_req_valid && !lc_req_ready;
    held_lc_addr = lc_req_addr;
    held_lc_we   = lc_req_we;
    held_lc_line = lc_req_line;
    if (lc_req_valid && lc_req_ready) begin
      w = window_index(lc_req_addr) & ~1;
      checks++;
      if (!in_window(lc_req_addr) || lc_req_addr[3:0] != 4'h0) begin
        protocol_failure("lc request address is outside the window or not line aligned");
      end else if (lc_req_we) begin
        if (lc_req_line != {exp_mem[w + 1], exp_mem[w]}) begin
          value_mismatch("lc_req_line", lc_req_line, {exp_mem[w + 1], exp_mem[w]});
        end
        gold_mem[w]     = lc_req_line[63:0];
        gold_mem[w + 1] = lc_req_line[127:64];
      end else begin
        foreach (rd_line_q[i]) begin
          if (rd_line_q[i] == lc_req_addr) begin
            protocol_failure("second lc read issued for a line already being fetched");
          end
        end
        rd_line_q.push_back(lc_req_addr);
        rd_wait_q.push_back(1 + ($random(seed) & 7));
      end
    end
    if (lc_resp_valid && lc_resp_ready) begin
      void'(rd_line_q.pop_front());
      void'(rd_wait_q.pop_front());
      resp_taken = 1'b1;
    end
  endtask

  task automatic lc_drive();
    int w;
    pick_ready(lc_stretch, lc_req_ready);
    foreach (rd_wait_q[i]) begin
      if (rd_wait_q[i] > 0) rd_wait_q[i]--;
    end
    if (resp_taken) begin
      lc_resp_valid = 1'b0;
      resp_taken    = 1'b0;
    end
    if (!lc_resp_valid && rd_line_q.size() > 0 && rd_wait_q[0] == 0) begin
      w             = window_index(rd_line_q[0]);
      lc_resp_addr  = rd_line_q[0];
      lc_resp_line  = {gold_mem[w + 1], gold_mem[w]};
      lc_resp_valid = 1'b1;
    end
  endtask

//--- tests/tb_l1d.sv
`timescale 1ns/1ps
/*
 tb_l1d
 Testbench for the L1 data cache. Random LSU traffic over a 64-word window,
 a lower-cache model with golden memory, and checks of every response.
*/
module tb_l1d;

  localparam int          NUM_REQS  = 400;
  localparam int          WIN_WORDS = 64;
  localparam logic [15:0] WIN_BASE  = 16'h3a00;

  logic              clk_in = 1'b0;
  logic              rst_N_in;
  logic              lsu_req_valid;
  logic              lsu_req_ready;
  l1d_pkg::paddr_t   lsu_req_addr;
  logic              lsu_req_we;
  l1d_pkg::word_t    lsu_req_data;
  l1d_pkg::req_tag_t lsu_req_tag;
  logic              lsu_resp_valid;
  logic              lsu_resp_ready;
  l1d_pkg::word_t    lsu_resp_data;
  l1d_pkg::req_tag_t lsu_resp_tag;
  logic              lsu_resp_write;
  logic              lc_req_valid;
  logic              lc_req_ready;
  l1d_pkg::paddr_t   lc_req_addr;
  logic              lc_req_we;
  l1d_pkg::line_t    lc_req_line;
  logic              lc_resp_valid;
  logic              lc_resp_ready;
  l1d_pkg::paddr_t   lc_resp_addr;
  l1d_pkg::line_t    lc_resp_line;

  integer            seed;
  int                errors;
  int                checks;
  int                accepted;
  int                issued;
  int                responses;
  int                resp_stretch;
  logic              bp;
  logic              req_taken;
  logic              hold_resp;
  l1d_pkg::word_t    held_resp_data;
  l1d_pkg::req_tag_t held_resp_tag;
  logic              held_resp_write;
  l1d_pkg::word_t    exp_mem [WIN_WORDS];
  l1d_pkg::word_t    exp_load [16];
  logic [15:0]       pending;
  logic [15:0]       pend_we;

  l1d_top UUT (.*);

  always #20 clk_in = ~clk_in;

  task automatic value_mismatch(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
    errors++;
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
  endtask

  task automatic protocol_failure(input string msg);
    errors++;
    $display("%s at %0t ns", msg, $time);
  endtask

  function automatic int window_index(input l1d_pkg::paddr_t a);
    return int'((a - WIN_BASE) >> 3);
  endfunction

  function automatic logic in_window(input l1d_pkg::paddr_t a);
    return a >= WIN_BASE && int'(a) < int'(WIN_BASE) + WIN_WORDS * 8;
  endfunction

  // ready stays high without back-pressure, otherwise drops for random stretches
  task automatic pick_ready(inout int stretch, output logic ready);
    if (!bp) begin
      stretch = 0;
      ready   = 1'b1;
    end else if (stretch > 0) begin
      stretch--;
      ready = 1'b0;
    end else if (($random(seed) & 7) == 0) begin
      stretch = $random(seed) & 7;
      ready   = 1'b0;
    end else begin
      ready = 1'b1;
    end
  endtask

`include "tb_lc_model.svh"

  task automatic lsu_observe();
    int w;
    int t;
    if (hold_resp) begin
      checks++;
      if (!lsu_resp_valid) protocol_failure("lsu response dropped before it was taken");
      if (lsu_resp_tag != held_resp_tag) begin
        value_mismatch("lsu_resp_tag", lsu_resp_tag, held_resp_tag);
      end
      if (lsu_resp_data != held_resp_data) begin
        value_mismatch("lsu_resp_data", lsu_resp_data, held_resp_data);
      end
      if (lsu_resp_write != held_resp_write) begin
        value_mismatch("lsu_resp_write", lsu_resp_write, held_resp_write);
      end
    end
    hold_resp       = lsu_resp_valid && !lsu_resp_ready;
    held_resp_data  = lsu_resp_data;
    held_resp_tag   = lsu_resp_tag;
    held_resp_write = lsu_resp_write;
    // operations on one address take effect in acceptance order
    if (lsu_req_valid && lsu_req_ready) begin
      w = window_index(lsu_req_addr);
      t = lsu_req_tag;
      if (pending[t]) protocol_failure("request tag reused while still outstanding");
      pending[t] = 1'b1;
      pend_we[t] = lsu_req_we;
      if (lsu_req_we) begin
        exp_mem[w] = lsu_req_data;
      end else begin
        exp_load[t] = exp_mem[w];
      end
      accepted++;
      req_taken = 1'b1;
    end
    if (lsu_resp_valid && lsu_resp_ready) begin
      t = lsu_resp_tag;
      checks++;
      if (!pending[t]) begin
        protocol_failure($sformatf("response for tag %0d with no request outstanding", t));
      end else begin
        if (lsu_resp_write != pend_we[t]) begin
          value_mismatch("lsu_resp_write", lsu_resp_write, pend_we[t]);
        end
        if (!pend_we[t] && lsu_resp_data != exp_load[t]) begin
          value_mismatch("lsu_resp_data", lsu_resp_data, exp_load[t]);
        end
        if (pend_we[t] && lsu_resp_data != '0) begin
          value_mismatch("lsu_resp_data", lsu_resp_data, 0);
        end
        pending[t] = 1'b0;
      end
      responses++;
    end
  endtask

  task automatic lsu_drive();
    if (req_taken) begin
      lsu_req_valid = 1'b0;
      req_taken     = 1'b0;
    end
    if (!lsu_req_valid && issued < NUM_REQS && ($random(seed) & 3) != 0) begin
      lsu_req_addr  = WIN_BASE + 16'(($random(seed) & (WIN_WORDS - 1)) * 8);
      lsu_req_we    = $random(seed) & 1;
      lsu_req_data  = {$random(seed), $random(seed)};
      lsu_req_tag   = 4'(issued);
      lsu_req_valid = 1'b1;
      issued++;
    end
    pick_ready(resp_stretch, lsu_resp_ready);
  endtask

  // sample at the falling edge, drive 2 ns after the rising edge
  task automatic run_cycle();
    @(negedge clk_in);
    lsu_observe();
    lc_observe();
    @(posedge clk_in);
    #2;
    lsu_drive();
    lc_drive();
  endtask

  task automatic report_test(input string name, input int base_errors);
    $display("test %s finished with %0d errors", name, errors - base_errors);
  endtask

  initial begin
    int base_err;
    seed           = 32'he82d;
    errors         = 0;
    checks         = 0;
    accepted       = 0;
    issued         = 0;
    responses      = 0;
    resp_stretch   = 0;
    bp             = 1'b0;
    req_taken      = 1'b0;
    hold_resp      = 1'b0;
    pending        = '0;
    pend_we        = '0;
    rst_N_in       = 1'b0;
    lsu_req_valid  = 1'b0;
    lsu_req_addr   = '0;
    lsu_req_we     = 1'b0;
    lsu_req_data   = '0;
    lsu_req_tag    = '0;
    lsu_resp_ready = 1'b0;
    lc_req_ready   = 1'b0;
    lc_resp_valid  = 1'b0;
    lc_resp_addr   = '0;
    lc_resp_line   = '0;
    init_memory();
    repeat (2) @(posedge clk_in);
    #2;
    rst_N_in = 1'b1;

    base_err = errors;
    @(negedge clk_in);
    checks += 2;
    if (lsu_resp_valid !== 1'b0) value_mismatch("lsu_resp_valid", lsu_resp_valid, 0);
    if (lc_req_valid !== 1'b0) value_mismatch("lc_req_valid", lc_req_valid, 0);
    report_test("reset_idle", base_err);

    base_err = errors;
    while (accepted < NUM_REQS / 2) run_cycle();
    report_test("random_traffic", base_err);

    base_err = errors;
    bp = 1'b1;
    while (accepted < NUM_REQS) run_cycle();
    report_test("backpressure_traffic", base_err);

    base_err = errors;
    bp = 1'b0;
    while (responses < accepted || rd_line_q.size() != 0) run_cycle();
    for (int t = 0; t < 16; t++) begin
      checks++;
      if (pending[t]) protocol_failure($sformatf("tag %0d was never answered", t));
    end
    report_test("completion", base_err);

    $display("tests: 4, checks: %0d, errors: %0d, requests: %0d, responses: %0d",
             checks, errors, accepted, responses);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_REQS * 200 * 40);
    $display("watchdog expired with %0d of %0d responses received", responses, accepted);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tests
verilog/l1d_pkg.sv
verilog/array_port_if.sv
verilog/mshr_port_if.sv
verilog/l1d_line_store.sv
verilog/l1d_mshr_file.sv
verilog/l1d_controller.sv
verilog/l1d_top.sv
tests/tb_l1d.sv
